// File: hdl/mem_link_pkg.sv
`default_nettype none

package mem_link_pkg;

  // Field widths.
  localparam int CORD_W = 4;
  localparam int ADDR_W = 16;
  localparam int DATA_W = 32;
  localparam int OP_W   = 2;

  localparam int MSG_W  = OP_W + ADDR_W + DATA_W;
  localparam int FLIT_W = 2 * CORD_W + MSG_W;

  // Bit positions inside a message.
  localparam int MSG_DATA_LSB = 0;
  localparam int MSG_ADDR_LSB = DATA_W;
  localparam int MSG_OP_LSB   = DATA_W + ADDR_W;

  // Bit positions inside a flit, dst cord on top.
  localparam int FLIT_SRC_LSB = MSG_W;
  localparam int FLIT_DST_LSB = MSG_W + CORD_W;

  typedef logic [CORD_W-1:0] cord_t;
  typedef logic [ADDR_W-1:0] mem_addr_t;
  typedef logic [DATA_W-1:0] mem_data_t;
  typedef logic [OP_W-1:0]   mem_op_t;

  // {op, addr, data}
  typedef logic [MSG_W-1:0]  mem_msg_t;

  // {dst, src, msg}
  typedef logic [FLIT_W-1:0] flit_t;

  localparam mem_op_t MEM_OP_RD = 2'b00;
  localparam mem_op_t MEM_OP_WR = 2'b01; // Also the write ack opcode.

endpackage

`default_nettype wire

// File: hdl/link_credit_counter.sv
`timescale 1ns/1ns
`default_nettype none

module link_credit_counter
  #(parameter int credits_p = 4)
  (input  logic   clk_i
   , input  logic rst_n_i

   , input  logic send_i   // One flit leaves this cycle.
   , input  logic credit_i // Receiver drained one flit.
   , output logic has_credit_o
   );

  localparam int cnt_w_lp = $clog2(credits_p + 1);

  logic [cnt_w_lp-1:0] credit_cnt_r;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      credit_cnt_r <= cnt_w_lp'(credits_p); // Receiver buffer starts empty.
    end else if (send_i && !credit_i) begin
      credit_cnt_r <= credit_cnt_r - cnt_w_lp'(1);
    end else if (credit_i && !send_i) begin
      credit_cnt_r <= credit_cnt_r + cnt_w_lp'(1);
    end
  end

  // Sender may raise valid only with a credit in hand.
  assign has_credit_o = (credit_cnt_r != '0);

endmodule

`default_nettype wire

// File: hdl/link_rx_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module link_rx_fifo
  #(parameter int credits_p = 4)
  (input  logic                  clk_i
   , input  logic                rst_n_i

   , input  mem_link_pkg::flit_t flit_i
   , input  logic                flit_v_i

   , output mem_link_pkg::flit_t flit_o
   , output logic                flit_v_o
   , input  logic                pop_i

   , output logic                credit_o
   );

  import mem_link_pkg::*;

  localparam int ptr_w_lp = $clog2(credits_p);
  localparam int cnt_w_lp = $clog2(credits_p + 1);

  flit_t               mem_r [credits_p];
  logic [ptr_w_lp-1:0] wr_ptr_r;
  logic [ptr_w_lp-1:0] rd_ptr_r;
  logic [cnt_w_lp-1:0] cnt_r;
  logic                pop;
  logic                credit_r;

  // Space is guaranteed by the sender's credits.
  assign pop = pop_i & flit_v_o;

  always_ff @(posedge clk_i) begin
    if (flit_v_i) begin
      mem_r[wr_ptr_r] <= flit_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      cnt_r    <= '0;
      credit_r <= 1'b0;
    end else begin
      credit_r <= pop; // Credit goes back one cycle after the pop.
      if (flit_v_i) begin
        wr_ptr_r <= (wr_ptr_r == ptr_w_lp'(credits_p - 1)) ? '0 : wr_ptr_r + ptr_w_lp'(1);
      end
      if (pop) begin
        rd_ptr_r <= (rd_ptr_r == ptr_w_lp'(credits_p - 1)) ? '0 : rd_ptr_r + ptr_w_lp'(1);
      end
      case ({flit_v_i, pop})
        2'b10:   cnt_r <= cnt_r + cnt_w_lp'(1);
        2'b01:   cnt_r <= cnt_r - cnt_w_lp'(1);
        default: cnt_r <= cnt_r;
      endcase
    end
  end

  assign flit_o   = mem_r[rd_ptr_r];
  assign flit_v_o = (cnt_r != '0);
  assign credit_o = credit_r;

endmodule

`default_nettype wire

// File: hdl/mem_link_master.sv
`timescale 1ns/1ns
`default_nettype none

module mem_link_master
  #(parameter int credits_p = 4)
  (input  logic                     clk_i
   , input  logic                   rst_n_i

   , input  mem_link_pkg::cord_t    my_cord_i
   , input  mem_link_pkg::cord_t    dst_cord_i

   // Local command side.
   , input  mem_link_pkg::mem_msg_t mem_cmd_i
   , input  logic                   mem_cmd_v_i
   , output logic                   mem_cmd_ready_o

   , output mem_link_pkg::mem_msg_t mem_resp_o
   , output logic                   mem_resp_v_o
   , input  logic                   mem_resp_yumi_i

   // Command link, sending end.
   , output mem_link_pkg::flit_t    cmd_link_data_o
   , output logic                   cmd_link_v_o
   , input  logic                   cmd_link_credit_i

   // Response link, receiving end.
   , input  mem_link_pkg::flit_t    resp_link_data_i
   , input  logic                   resp_link_v_i
   , output logic                   resp_link_credit_o
   );

  import mem_link_pkg::*;

  logic  has_credit;
  logic  cmd_send;
  logic  cmd_accept;
  flit_t cmd_flit_r;
  logic  cmd_flit_v_r;
  flit_t resp_head;

  // Flit waits in the output register until a credit is in hand.
  assign cmd_send        = cmd_flit_v_r & has_credit;
  assign mem_cmd_ready_o = has_credit & (~cmd_flit_v_r | cmd_send);
  assign cmd_accept      = mem_cmd_v_i & mem_cmd_ready_o;

  always_ff @(posedge clk_i) begin
    if (cmd_accept) begin
      cmd_flit_r <= {dst_cord_i, my_cord_i, mem_cmd_i};
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cmd_flit_v_r <= 1'b0;
    end else if (cmd_accept) begin
      cmd_flit_v_r <= 1'b1;
    end else if (cmd_send) begin
      cmd_flit_v_r <= 1'b0;
    end
  end

  assign cmd_link_data_o = cmd_flit_r;
  assign cmd_link_v_o    = cmd_send;

  link_credit_counter
    #(.credits_p(credits_p))
    cmd_credits
    (.clk_i(clk_i)
     ,.rst_n_i(rst_n_i)
     ,.send_i(cmd_send)
     ,.credit_i(cmd_link_credit_i)
     ,.has_credit_o(has_credit)
     );

  // Response flits from the client side.
  link_rx_fifo
    #(.credits_p(credits_p))
    resp_fifo
    (.clk_i(clk_i)
     ,.rst_n_i(rst_n_i)
     ,.flit_i(resp_link_data_i)
     ,.flit_v_i(resp_link_v_i)
     ,.flit_o(resp_head)
     ,.flit_v_o(mem_resp_v_o)
     ,.pop_i(mem_resp_yumi_i)
     ,.credit_o(resp_link_credit_o)
     );

  assign mem_resp_o = resp_head[MSG_W-1:0]; // Cords are dropped here.

endmodule

`default_nettype wire

// File: hdl/mem_link_client.sv
`timescale 1ns/1ns
`default_nettype none

module mem_link_client
  #(parameter int credits_p = 4)
  (input  logic                     clk_i
   , input  logic                   rst_n_i

   , input  mem_link_pkg::cord_t    my_cord_i

   // Local memory side.
   , output mem_link_pkg::mem_msg_t mem_cmd_o
   , output logic                   mem_cmd_v_o
   , input  logic                   mem_cmd_yumi_i

   , input  mem_link_pkg::mem_msg_t mem_resp_i
   , input  logic                   mem_resp_v_i
   , output logic                   mem_resp_ready_o

   // Command link, receiving end.
   , input  mem_link_pkg::flit_t    cmd_link_data_i
   , input  logic                   cmd_link_v_i
   , output logic                   cmd_link_credit_o

   // Response link, sending end.
   , output mem_link_pkg::flit_t    resp_link_data_o
   , output logic                   resp_link_v_o
   , input  logic                   resp_link_credit_i
   );

  import mem_link_pkg::*;

  localparam int ptr_w_lp = $clog2(credits_p);
  localparam int cnt_w_lp = $clog2(credits_p + 1);

  flit_t               cmd_head;
  cord_t               cmd_src_cord;
  cord_t               ret_mem_r [credits_p];
  logic [ptr_w_lp-1:0] ret_wr_ptr_r;
  logic [ptr_w_lp-1:0] ret_rd_ptr_r;
  logic [cnt_w_lp-1:0] ret_cnt_r;
  logic                ret_empty;
  logic                ret_bypass;
  logic                ret_wr;
  logic                ret_rd;
  cord_t               ret_cord;
  logic                has_credit;
  logic                resp_send;
  logic                resp_accept;
  flit_t               resp_flit_r;
  logic                resp_flit_v_r;

  link_rx_fifo
    #(.credits_p(credits_p))
    cmd_fifo
    (.clk_i(clk_i)
     ,.rst_n_i(rst_n_i)
     ,.flit_i(cmd_link_data_i)
     ,.flit_v_i(cmd_link_v_i)
     ,.flit_o(cmd_head)
     ,.flit_v_o(mem_cmd_v_o)
     ,.pop_i(mem_cmd_yumi_i)
     ,.credit_o(cmd_link_credit_o)
     );

  assign mem_cmd_o    = cmd_head[MSG_W-1:0];
  assign cmd_src_cord = cmd_head[FLIT_SRC_LSB +: CORD_W];

  // Return-address queue, with a bypass for a same-cycle answer.
  assign ret_empty  = (ret_cnt_r == '0);
  assign ret_bypass = ret_empty & mem_cmd_yumi_i & resp_accept;
  assign ret_wr     = mem_cmd_v_o & mem_cmd_yumi_i & ~ret_bypass;
  assign ret_rd     = resp_accept & ~ret_empty;
  assign ret_cord   = ret_empty ? cmd_src_cord : ret_mem_r[ret_rd_ptr_r];

  always_ff @(posedge clk_i) begin
    if (ret_wr) begin
      ret_mem_r[ret_wr_ptr_r] <= cmd_src_cord;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ret_wr_ptr_r <= '0;
      ret_rd_ptr_r <= '0;
      ret_cnt_r    <= '0;
    end else begin
      if (ret_wr) begin
        ret_wr_ptr_r <= (ret_wr_ptr_r == ptr_w_lp'(credits_p - 1)) ?
                        '0 : ret_wr_ptr_r + ptr_w_lp'(1);
      end
      if (ret_rd) begin
        ret_rd_ptr_r <= (ret_rd_ptr_r == ptr_w_lp'(credits_p - 1)) ?
                        '0 : ret_rd_ptr_r + ptr_w_lp'(1);
      end
      case ({ret_wr, ret_rd})
        2'b10:   ret_cnt_r <= ret_cnt_r + cnt_w_lp'(1);
        2'b01:   ret_cnt_r <= ret_cnt_r - cnt_w_lp'(1);
        default: ret_cnt_r <= ret_cnt_r;
      endcase
    end
  end

  assign resp_send        = resp_flit_v_r & has_credit;
  assign mem_resp_ready_o = has_credit & (~resp_flit_v_r | resp_send);
  assign resp_accept      = mem_resp_v_i & mem_resp_ready_o;

  always_ff @(posedge clk_i) begin
    if (resp_accept) begin
      resp_flit_r <= {ret_cord, my_cord_i, mem_resp_i}; // Back to the requester.
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      resp_flit_v_r <= 1'b0;
    end else if (resp_accept) begin
      resp_flit_v_r <= 1'b1;
    end else if (resp_send) begin
      resp_flit_v_r <= 1'b0;
    end
  end

  link_credit_counter
    #(.credits_p(credits_p))
    resp_credits
    (.clk_i(clk_i)
     ,.rst_n_i(rst_n_i)
     ,.send_i(resp_send)
     ,.credit_i(resp_link_credit_i)
     ,.has_credit_o(has_credit)
     );

  assign resp_link_data_o = resp_flit_r;
  assign resp_link_v_o    = resp_send;

endmodule

`default_nettype wire

// File: hdl/mem_link_bidir.sv
`timescale 1ns/1ns
`default_nettype none

module mem_link_bidir
  #(parameter int credits_p = 4)
  (input  logic                     clk_i
   , input  logic                   rst_n_i

   , input  mem_link_pkg::cord_t    my_cord_i
   , input  mem_link_pkg::cord_t    dst_cord_i

   // Master side, toward the cache controller.
   , input  mem_link_pkg::mem_msg_t mem_cmd_i
   , input  logic                   mem_cmd_v_i
   , output logic                   mem_cmd_ready_o

   , output mem_link_pkg::mem_msg_t mem_resp_o
   , output logic                   mem_resp_v_o
   , input  logic                   mem_resp_yumi_i

   // Client side, toward the memory.
   , output mem_link_pkg::mem_msg_t mem_cmd_o
   , output logic                   mem_cmd_v_o
   , input  logic                   mem_cmd_yumi_i

   , input  mem_link_pkg::mem_msg_t mem_resp_i
   , input  logic                   mem_resp_v_i
   , output logic                   mem_resp_ready_o

   // Command link.
   , input  mem_link_pkg::flit_t    cmd_link_data_i
   , input  logic                   cmd_link_v_i
   , output logic                   cmd_link_credit_o
   , output mem_link_pkg::flit_t    cmd_link_data_o
   , output logic                   cmd_link_v_o
   , input  logic                   cmd_link_credit_i

   // Response link.
   , input  mem_link_pkg::flit_t    resp_link_data_i
   , input  logic                   resp_link_v_i
   , output logic                   resp_link_credit_o
   , output mem_link_pkg::flit_t    resp_link_data_o
   , output logic                   resp_link_v_o
   , input  logic                   resp_link_credit_i
   );

  mem_link_master
    #(.credits_p(credits_p))
    master_link
    (.clk_i(clk_i)
     ,.rst_n_i(rst_n_i)
     ,.my_cord_i(my_cord_i)
     ,.dst_cord_i(dst_cord_i)
     ,.mem_cmd_i(mem_cmd_i)
     ,.mem_cmd_v_i(mem_cmd_v_i)
     ,.mem_cmd_ready_o(mem_cmd_ready_o)
     ,.mem_resp_o(mem_resp_o)
     ,.mem_resp_v_o(mem_resp_v_o)
     ,.mem_resp_yumi_i(mem_resp_yumi_i)
     ,.cmd_link_data_o(cmd_link_data_o)   // Forward command traffic.
     ,.cmd_link_v_o(cmd_link_v_o)
     ,.cmd_link_credit_i(cmd_link_credit_i)
     ,.resp_link_data_i(resp_link_data_i)
     ,.resp_link_v_i(resp_link_v_i)
     ,.resp_link_credit_o(resp_link_credit_o) // Credits for responses.
     );

  mem_link_client
    #(.credits_p(credits_p))
    client_link
    (.clk_i(clk_i)
     ,.rst_n_i(rst_n_i)
     ,.my_cord_i(my_cord_i)
     ,.mem_cmd_o(mem_cmd_o)
     ,.mem_cmd_v_o(mem_cmd_v_o)
     ,.mem_cmd_yumi_i(mem_cmd_yumi_i)
     ,.mem_resp_i(mem_resp_i)
     ,.mem_resp_v_i(mem_resp_v_i)
     ,.mem_resp_ready_o(mem_resp_ready_o)
     ,.cmd_link_data_i(cmd_link_data_i)
     ,.cmd_link_v_i(cmd_link_v_i)
     ,.cmd_link_credit_o(cmd_link_credit_o)
     ,.resp_link_data_o(resp_link_data_o)
     ,.resp_link_v_o(resp_link_v_o)
     ,.resp_link_credit_i(resp_link_credit_i)
     );

endmodule

`default_nettype wire

// File: bench/tb_clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen
  #(parameter int period_p = 40
    , parameter int reset_cycles_p = 5)
  (output logic clk_o
   , output logic rst_n_o
   );

  initial begin
    clk_o = 1'b0;
    forever #(period_p / 2) clk_o = ~clk_o;
  end

  // Release on a falling edge, away from the sampling edge.
  initial begin
    rst_n_o = 1'b0;
    repeat (reset_cycles_p) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

// File: bench/mem_link_assertions.sv
`timescale 1ns/1ns
`default_nettype none

module mem_link_assertions
  #(parameter int credits_p = 4)
  (input  logic                             clk_i
   , input  logic                           rst_n_i
   , input  logic [$clog2(credits_p+1)-1:0] credit_cnt_i
   , input  logic [$clog2(credits_p+1)-1:0] rx_cnt_i // Receive buffer occupancy.
   , input  logic                           rx_v_i   // Valid on the receiving link.
   , input  logic                           yumi_i
   , input  logic                           v_i
   );

  logic failed = 1'b0; // Sticky, set by any violation.

  a_credit_max: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    32'(credit_cnt_i) <= credits_p)
    else begin
      failed = 1'b1;
      $error("credit count %0d above buffer depth %0d", credit_cnt_i, credits_p);
    end

  // The far sender has no credit left while this buffer is full.
  a_valid_needs_credit: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rx_v_i |-> (32'(rx_cnt_i) < credits_p))
    else begin
      failed = 1'b1;
      $error("link valid raised while the receive buffer was full");
    end

  // Yumi only on an offered entry.
  a_yumi_needs_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    yumi_i |-> v_i)
    else begin
      failed = 1'b1;
      $error("yumi raised while nothing was offered");
    end

endmodule

bind mem_link_master mem_link_assertions #(.credits_p(credits_p)) link_chk
  (.clk_i(clk_i)
   ,.rst_n_i(rst_n_i)
   ,.credit_cnt_i(cmd_credits.credit_cnt_r)
   ,.rx_cnt_i(resp_fifo.cnt_r)
   ,.rx_v_i(resp_link_v_i)
   ,.yumi_i(mem_resp_yumi_i)
   ,.v_i(mem_resp_v_o)
   );

bind mem_link_client mem_link_assertions #(.credits_p(credits_p)) link_chk
  (.clk_i(clk_i)
   ,.rst_n_i(rst_n_i)
   ,.credit_cnt_i(resp_credits.credit_cnt_r)
   ,.rx_cnt_i(cmd_fifo.cnt_r)
   ,.rx_v_i(cmd_link_v_i)
   ,.yumi_i(mem_cmd_yumi_i)
   ,.v_i(mem_cmd_v_o)
   );

`default_nettype wire

// File: bench/mem_link_bidir_tb.sv
`timescale 1ns/1ns
`default_nettype none

module mem_link_bidir_tb;

  import mem_link_pkg::*;

  localparam int    credits_lp     = 4;
  localparam int    drive_delay_lp = 2;
  localparam cord_t node_cord_lp   = 4'h6; // Loopback, so source and destination match.

  logic     clk;
  logic     rst_n;
  mem_msg_t mem_cmd_i;
  logic     mem_cmd_v_i;
  logic     mem_cmd_ready_o;
  mem_msg_t mem_resp_o;
  logic     mem_resp_v_o;
  logic     mem_resp_yumi_i;
  mem_msg_t mem_cmd_o;
  logic     mem_cmd_v_o;
  logic     mem_cmd_yumi_i;
  mem_msg_t mem_resp_i;
  logic     mem_resp_v_i;
  logic     mem_resp_ready_o;
  flit_t    cmd_link_data;
  logic     cmd_link_v;
  logic     cmd_link_credit;
  flit_t    resp_link_data;
  logic     resp_link_v;
  logic     resp_link_credit;

  int        trace_test [$];
  mem_msg_t  trace_cmd [$];
  mem_msg_t  trace_exp [$];
  logic      trace_loaded = 1'b0;
  mem_msg_t  cmd_q [$];      // Commands not yet taken by the master.
  mem_msg_t  exp_q [$];      // Expected responses, in command order.
  mem_msg_t  mem_resp_q [$]; // Memory answers not yet taken by the client.
  mem_data_t mem_model [mem_addr_t];
  logic      mem_stall   = 1'b0;
  logic      resp_random = 1'b0;
  logic [31:0] rng_state = 32'h4971;
  int        accepted = 0;
  int        errors = 0;
  int        checks = 0;
  int        tests_run = 0;

  tb_clock_gen #(.period_p(40), .reset_cycles_p(5)) clock_gen
    (.clk_o(clk)
     ,.rst_n_o(rst_n)
     );

  mem_link_bidir #(.credits_p(credits_lp)) mem_link_bidir_inst
    (.clk_i(clk)
     ,.rst_n_i(rst_n)
     ,.my_cord_i(node_cord_lp)
     ,.dst_cord_i(node_cord_lp)
     ,.mem_cmd_i(mem_cmd_i)
     ,.mem_cmd_v_i(mem_cmd_v_i)
     ,.mem_cmd_ready_o(mem_cmd_ready_o)
     ,.mem_resp_o(mem_resp_o)
     ,.mem_resp_v_o(mem_resp_v_o)
     ,.mem_resp_yumi_i(mem_resp_yumi_i)
     ,.mem_cmd_o(mem_cmd_o)
     ,.mem_cmd_v_o(mem_cmd_v_o)
     ,.mem_cmd_yumi_i(mem_cmd_yumi_i)
     ,.mem_resp_i(mem_resp_i)
     ,.mem_resp_v_i(mem_resp_v_i)
     ,.mem_resp_ready_o(mem_resp_ready_o)
     ,.cmd_link_data_i(cmd_link_data)   // Each link output feeds its own input.
     ,.cmd_link_v_i(cmd_link_v)
     ,.cmd_link_credit_o(cmd_link_credit)
     ,.cmd_link_data_o(cmd_link_data)
     ,.cmd_link_v_o(cmd_link_v)
     ,.cmd_link_credit_i(cmd_link_credit)
     ,.resp_link_data_i(resp_link_data)
     ,.resp_link_v_i(resp_link_v)
     ,.resp_link_credit_o(resp_link_credit)
     ,.resp_link_data_o(resp_link_data)
     ,.resp_link_v_o(resp_link_v)
     ,.resp_link_credit_i(resp_link_credit)
     );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic check_msg(input mem_msg_t got, input mem_msg_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t ns: %s, got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_cord(input cord_t got, input cord_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t ns: %s, got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t ns: %s, got %b, expected %b", $time, what, got, exp);
    end
  endtask

  // Columns: test, op, addr, write data, expected response data.
  initial begin : read_trace
    int        fd;
    int        code;
    int        tid;
    string     tok;
    string     rest;
    mem_op_t   op;
    mem_addr_t addr;
    mem_data_t wdata;
    mem_data_t rdata;
    fd = $fopen("bench/mem_link_trace.txt", "r");
    if (fd == 0) begin
      $display("Could not open the trace file bench/mem_link_trace.txt");
      $display("Simulation finished: FAIL");
      $finish;
    end else begin
      code = $fscanf(fd, "%s", tok);
      while (code == 1) begin
        if (tok[0] == "#") begin
          code = $fgets(rest, fd);
        end else begin
          code = $sscanf(tok, "%d", tid);
          code = $fscanf(fd, "%h %h %h %h", op, addr, wdata, rdata);
          trace_test.push_back(tid);
          trace_cmd.push_back({op, addr, wdata});
          trace_exp.push_back({op, addr, rdata});
        end
        code = $fscanf(fd, "%s", tok);
      end
      $fclose(fd);
      trace_loaded = 1'b1;
    end
  end

  // Command source, memory model and response consumer, all driven after the edge.
  initial begin : cycle_driver
    mem_msg_t  cmd;
    mem_op_t   op;
    mem_addr_t addr;
    mem_data_t data;
    mem_cmd_i       = '0;
    mem_cmd_v_i     = 1'b0;
    mem_resp_yumi_i = 1'b0;
    mem_cmd_yumi_i  = 1'b0;
    mem_resp_i      = '0;
    mem_resp_v_i    = 1'b0;
    forever begin
      @(posedge clk);
      #(drive_delay_lp);
      rng_state = xorshift32(rng_state);
      if (rst_n) begin
        mem_cmd_v_i = (cmd_q.size() != 0);
        if (mem_cmd_v_i) begin
          mem_cmd_i = cmd_q[0];
          if (mem_cmd_ready_o) begin // Taken at the next edge.
            void'(cmd_q.pop_front());
            accepted++;
          end
        end
        mem_resp_v_i = (mem_resp_q.size() != 0);
        if (mem_resp_v_i) begin
          mem_resp_i = mem_resp_q[0];
          if (mem_resp_ready_o) void'(mem_resp_q.pop_front());
        end
        // One response slot, like a simple SRAM port.
        mem_cmd_yumi_i = mem_cmd_v_o && !mem_stall && (mem_resp_q.size() == 0)
                         && (rng_state[1:0] != 2'b00);
        if (mem_cmd_yumi_i) begin
          cmd  = mem_cmd_o;
          op   = cmd[MSG_OP_LSB +: OP_W];
          addr = cmd[MSG_ADDR_LSB +: ADDR_W];
          data = cmd[MSG_DATA_LSB +: DATA_W];
          if (op == MEM_OP_WR) begin
            mem_model[addr] = data;
          end else begin
            data = mem_model.exists(addr) ? mem_model[addr] : '0;
          end
          mem_resp_q.push_back({op, addr, data});
        end
        mem_resp_yumi_i = mem_resp_v_o && (!resp_random || rng_state[5]);
        if (mem_resp_yumi_i) begin
          if (exp_q.size() == 0) begin
            errors++;
            $display("Response arrived at %0t ns with no command outstanding", $time);
          end else begin
            check_msg(mem_resp_o, exp_q.pop_front(), "response message");
          end
        end
        if (resp_link_v) begin
          check_cord(resp_link_data[FLIT_SRC_LSB +: CORD_W], node_cord_lp, "flit source");
          check_cord(resp_link_data[FLIT_DST_LSB +: CORD_W], node_cord_lp, "flit destination");
        end
      end
    end
  end

  task automatic run_test(input int id, input string name, input logic stall,
                          input logic rand_yumi);
    int n;
    int err0;
    int acc0;
    int waited;
    n = 0;
    err0 = errors;
    acc0 = accepted;
    resp_random = rand_yumi;
    mem_stall = stall;
    foreach (trace_test[i]) begin
      if (trace_test[i] == id) begin
        cmd_q.push_back(trace_cmd[i]);
        exp_q.push_back(trace_exp[i]);
        n++;
      end
    end
    if (stall) begin
      waited = 0;
      while (mem_cmd_ready_o && waited < 40) begin
        @(negedge clk);
        waited++;
      end
      check_flag(mem_cmd_ready_o, 1'b0, "command ready with the memory stalled");
      repeat (8) @(negedge clk);
      check_flag((accepted - acc0) <= credits_lp + 1, 1'b1, "commands taken while stalled");
      check_flag(mem_cmd_ready_o, 1'b0, "command ready held low while stalled");
      mem_stall = 1'b0;
    end
    while (exp_q.size() != 0 || cmd_q.size() != 0) @(negedge clk);
    repeat (4) @(negedge clk);
    tests_run++;
    $display("test %0d %s: %0d commands, %0d errors", id, name, n, errors - err0);
  endtask

  initial begin : run_tests
    int err0;
    wait (trace_loaded);
    wait (rst_n);
    @(negedge clk);
    err0 = errors;
    check_flag(mem_cmd_ready_o, 1'b1, "command ready after reset");
    check_flag(mem_resp_v_o, 1'b0, "response valid after reset");
    check_flag(mem_resp_ready_o, 1'b1, "memory response ready after reset");
    check_flag(mem_cmd_v_o, 1'b0, "memory command valid after reset");
    check_flag(cmd_link_v, 1'b0, "command link valid after reset");
    check_flag(resp_link_v, 1'b0, "response link valid after reset");
    check_flag(cmd_link_credit, 1'b0, "command link credit after reset");
    check_flag(resp_link_credit, 1'b0, "response link credit after reset");
    tests_run++;
    $display("test 0 reset state: %0d errors", errors - err0);
    run_test(1, "write and read back", 1'b0, 1'b0);
    run_test(2, "memory stall", 1'b1, 1'b0);
    run_test(3, "consumer back-pressure", 1'b0, 1'b1);
    if (mem_link_bidir_inst.master_link.link_chk.failed ||
        mem_link_bidir_inst.client_link.link_chk.failed) begin
      errors++;
      $display("A bound link assertion was violated during the run");
    end
    $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  // Generous bound from the trace length.
  initial begin : watchdog
    wait (trace_loaded);
    repeat (trace_cmd.size() * 40 + 200) @(posedge clk);
    $display("Watchdog timeout, responses still missing after %0d cycles",
             trace_cmd.size() * 40 + 200);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: mem_link_bidir.f
hdl/mem_link_pkg.sv
hdl/link_credit_counter.sv
hdl/link_rx_fifo.sv
hdl/mem_link_master.sv
hdl/mem_link_client.sv
hdl/mem_link_bidir.sv
bench/tb_clock_gen.sv
bench/mem_link_assertions.sv
bench/mem_link_bidir_tb.sv

// File: Makefile
# Verilator build and run for the mem_link_bidir loopback testbench.
LOG = sim.log

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --timescale 1ns/1ns \
		-f mem_link_bidir.f --top-module mem_link_bidir_tb -Mdir obj_dir

run: compile
	./obj_dir/Vmem_link_bidir_tb > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Simulation finished: FAIL" $(LOG); then exit 1; fi
	@grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: bench/mem_link_trace.txt
# test op addr wdata expected_data  (test decimal, other fields hex)
# op 0 = read, 1 = write; expected_data is the data field of the response
1 1 0010 deadbeef deadbeef
1 0 0010 00000000 deadbeef
1 0 0020 00000000 00000000
1 1 0030 12345678 12345678
1 1 0031 a5a5a5a5 a5a5a5a5
1 0 0030 00000000 12345678
1 0 0031 00000000 a5a5a5a5
1 1 0010 0badf00d 0badf00d
1 0 0010 00000000 0badf00d
2 1 0100 11111111 11111111
2 1 0101 22222222 22222222
2 1 0102 33333333 33333333
2 0 0100 00000000 11111111
2 0 0101 00000000 22222222
2 1 0103 44444444 44444444
2 0 0102 00000000 33333333
2 0 0103 00000000 44444444
3 0 0010 00000000 0badf00d
3 1 ffff 80000001 80000001
3 0 ffff 00000000 80000001
3 0 0200 00000000 00000000
3 1 0200 cafef00d cafef00d
3 0 0200 00000000 cafef00d
3 0 0030 00000000 12345678
3 1 0030 00000000 00000000
3 0 0030 00000000 00000000
